//--- Bender.yml
package:
  name: zx_ula

export_include_dirs:
  - .

sources:
  - files:
      - ula_pkg.sv
      - video_timing.sv
      - screen_fetch.sv
      - io_ports.sv
      - mem_decoder.sv
      - zx_ula.sv
  - target: test
    files:
      - tb_zx_ula.sv

# header ula_config.svh sits in the package root

//--- io_ports.sv
`default_nettype none

module io_ports (
	input  wire                 clk14,
	input  wire                 rst_n,
	input  wire ula_pkg::cpu_bus_t cpu,
	input  wire [7:0]           vd_in,
	input  wire [4:0]           kd,
	input  wire                 tape_in,
	output logic [2:0]          border,
	output logic                beeper,
	output logic                tape_out,
	output ula_pkg::paging_t    paging,
	output logic [7:0]          vd_out,
	output logic                vd_oe
);
	logic io_req;
	logic port_fe_cs;
	logic port_7ffd_cs;
	logic [4:0] port_fe;

	// interrupt acknowledge also pulls n_iorq low, with n_m1
	assign io_req = !cpu.n_iorq && cpu.n_m1;
	assign port_fe_cs = io_req && !cpu.a0;
	assign port_7ffd_cs = io_req && !cpu.a1 && !cpu.a15;

	assign border = port_fe[2:0];
	assign tape_out = port_fe[3];
	assign beeper = port_fe[4];

	// #FE write
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			port_fe <= '0;
		end else if (port_fe_cs && !cpu.n_wr) begin
			port_fe <= vd_in[4:0];
		end
	end

	// #7FFD write, frozen once the lock bit is set
	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			paging <= '0;
		end else if (port_7ffd_cs && !cpu.n_wr && !paging.lock) begin
			paging <= '{
				rambank: vd_in[2:0],
				vbank: vd_in[3],
				rombank: vd_in[4],
				lock: vd_in[5]
			};
		end
	end

	// keyboard half-row and EAR input
	assign vd_out = {1'b1, tape_in, 1'b1, kd};

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			vd_oe <= 1'b0;
		end else begin
			vd_oe <= port_fe_cs && !cpu.n_rd;
		end
	end

	a_lock_holds: assert property (@(posedge clk14) disable iff (!rst_n)
		paging.lock |=> $stable(paging))
		else $error("paging changed while locked");

endmodule

`default_nettype wire

//--- mem_decoder.sv
`default_nettype none

module mem_decoder (
	input  wire                 clk14,
	input  wire                 rst_n,
	input  wire ula_pkg::cpu_bus_t cpu,
	input  wire ula_pkg::paging_t  paging,
	input  wire                 screen_read,
	input  wire [13:0]          screen_addr,
	output logic                n_romcs,
	output logic                n_vrd,
	output logic                n_vwr,
	output logic                rom_a14,
	output logic [18:13]        va_hi,
	output logic [12:0]         va_lo,
	output logic                va_lo_oe
);
	logic mem_req;
	logic rom_sel;
	logic ram_sel;
	logic n_romcs_q;
	logic n_ramcs;
	logic n_vwr_q;
	logic [18:13] ram_a;

	// refresh cycles select nothing
	assign mem_req = !cpu.n_mreq && cpu.n_rfsh;
	assign rom_sel = mem_req && !cpu.a15 && !cpu.a14;
	assign ram_sel = mem_req && (cpu.a15 || cpu.a14);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			n_romcs_q <= 1'b1;
			n_ramcs <= 1'b1;
			n_vwr_q <= 1'b1;
			ram_a <= '0;
		end else begin
			n_romcs_q <= !rom_sel;
			n_ramcs <= !ram_sel;
			n_vwr_q <= !ram_sel || cpu.n_wr;
			// #C000 is banked, #4000 is page 5 and #8000 is page 2
			if (cpu.a15 && cpu.a14) begin
				ram_a <= {2'b11, paging.rambank, cpu.a13};
			end else begin
				ram_a <= {2'b11, cpu.a14, cpu.a15, cpu.a14, cpu.a13};
			end
		end
	end

	// the live n_mreq ends the select with the bus cycle
	assign n_romcs = n_romcs_q | cpu.n_mreq;
	assign n_vrd = (n_ramcs | cpu.n_rd) & ~screen_read;
	assign n_vwr = n_vwr_q | cpu.n_wr | screen_read;
	assign rom_a14 = paging.rombank;

	// screen fetch reads page 5, or page 7 with vbank set
	assign va_hi = screen_read ? {3'b111, paging.vbank, 1'b1, screen_addr[13]} : ram_a;
	assign va_lo = screen_addr[12:0];
	assign va_lo_oe = screen_read;

endmodule

`default_nettype wire

//--- screen_fetch.sv
`default_nettype none

`include "ula_config.svh"

module screen_fetch (
	input  wire                clk14,
	input  wire                rst_n,
	input  wire ula_pkg::raster_t raster,
	input  wire ula_pkg::sync_t   sync,
	input  wire                ck7,
	input  wire                frame_start,
	input  wire ula_pkg::cpu_bus_t cpu,
	input  wire [2:0]          border,
	input  wire [7:0]          vd_in,
	output ula_pkg::rgbi_t     rgbi,
	output logic               screen_read,
	output logic [13:0]        screen_addr
);
	logic [8:0] hc;
	logic [8:0] vc;
	logic in_lines;
	logic fetch_q;
	logic cpu_idle;
	logic screen_update;
	logic screen_show;
	logic [13:0] bitmap_addr;
	logic [13:0] attr_addr;
	logic [7:0] attr_next;
	logic [7:0] bitmap_next;
	logic [7:0] attr;
	logic [7:0] bitmap;
	logic [4:0] blink_cnt;
	logic blink;
	logic ink_on;
	logic [2:0] grb;
	ula_pkg::rgbi_t colour_q;

	assign hc = raster.hc;
	assign vc = raster.vc;
	assign in_lines = vc < 9'(`ULA_V_AREA);

	// refresh cycles leave the video RAM free
	assign cpu_idle = (cpu.n_mreq || !cpu.n_rfsh) && cpu.n_iorq && cpu.n_m1;
	assign screen_read = fetch_q && cpu_idle;

	// ZX screen layout inside the 16K video page
	assign bitmap_addr = {1'b0, vc[7:6], vc[2:0], vc[5:3], hc[7:3]};
	assign attr_addr = {4'b0110, vc[7:3], hc[7:3]};
	// attribute on the even half-pixel, bitmap on the odd one
	assign screen_addr = ck7 ? bitmap_addr : attr_addr;

	// bytes of group k reach the shifter on the last half-pixel of that group
	assign screen_update = in_lines && (hc < 9'(`ULA_H_AREA)) && (raster.hc0[3:0] == 4'b1110);
	assign screen_show = in_lines && (hc >= 9'(`ULA_SCREEN_DELAY - 1)) &&
		(hc < 9'(`ULA_H_AREA + `ULA_SCREEN_DELAY - 1));

	assign blink = blink_cnt[4];

	always_comb begin
		ink_on = bitmap[7] ^ (attr[7] & blink);
		grb = ink_on ? attr[2:0] : attr[5:3];
	end

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			fetch_q <= 1'b0;
			blink_cnt <= '0;
			colour_q <= '0;
		end else begin
			fetch_q <= in_lines && (hc < 9'(`ULA_H_AREA));
			if (frame_start) begin
				blink_cnt <= blink_cnt + 5'd1;
			end
			if (ck7) begin
				if (screen_show) begin
					colour_q <= '{r: grb[1], g: grb[2], b: grb[0], i: (|grb) & attr[6]};
				end else begin
					colour_q <= '{r: border[1], g: border[2], b: border[0], i: 1'b0};
				end
			end
		end
	end

	always_ff @(posedge clk14) begin
		if (screen_read && !ck7) begin
			attr_next <= vd_in;
		end
		if (screen_read && ck7) begin
			bitmap_next <= vd_in;
		end
		if (screen_update) begin
			attr <= attr_next;
			bitmap <= bitmap_next;
		end else if (ck7) begin
			bitmap <= {bitmap[6:0], 1'b0};
		end
	end

	assign rgbi = sync.blank ? '0 : colour_q;

	// reads stay inside the active lines, one group past the picture at most
	a_fetch_in_picture: assert property (@(posedge clk14) disable iff (!rst_n)
		screen_read |-> in_lines && (hc <= 9'(`ULA_H_AREA)))
		else $error("screen read outside the picture fetch window");

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
ula_pkg.sv
video_timing.sv
screen_fetch.sv
io_ports.sv
mem_decoder.sv
zx_ula.sv
tb_zx_ula.sv

//--- tb_zx_ula.sv
`default_nettype none

module tb_zx_ula;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int LINE_CYCLES = 896;
	localparam int FRAME_128 = LINE_CYCLES * 311;
	localparam int FRAME_PENT = LINE_CYCLES * 320;
	// first 128K vsync comes 239 lines in, then one 128K and one Pentagon frame
	localparam int TIMEOUT_CYCLES = 3 * FRAME_PENT + 40000;
	// r g b i, ink 6 is red with green, paper 1 is blue, border 4 is green
	localparam logic [3:0] INK_RGBI = 4'b1100;
	localparam logic [3:0] PAPER_RGBI = 4'b0010;
	localparam logic [3:0] BORDER_RGBI = 4'b0100;

	logic clk14 = 1'b0;
	logic rst_n;
	logic timing_sel;
	logic a15, a14, a13, a1, a0;
	logic n_rd, n_wr, n_mreq, n_iorq, n_m1, n_rfsh;
	logic [7:0] cpu_data;
	logic [4:0] kd;
	logic tape_in;
	wire [7:0] vd_in;
	wire [7:0] vd_out;
	wire vd_oe;
	wire [18:13] va_hi;
	wire [12:0] va_lo;
	wire va_lo_oe;
	wire n_romcs, n_vrd, n_vwr, rom_a14, n_int, clkcpu;
	wire tape_out, beeper;
	wire r, g, b, i, hsync, vsync, csync;

	integer seed;
	int cycle = 0;
	logic sel_q;
	logic sel_seen = 1'b1;
	logic hsync_q, vsync_q, n_int_q, pic_q, in_pic;
	logic hs_valid = 1'b0;
	logic vs_valid = 1'b0;
	logic int_open = 1'b0;
	logic [3:0] pix;
	logic [3:0] pix_q;
	int hs_last, vs_last, int_start, frame_len, int_width;
	int hs_checks = 0;
	int vs_rises = 0;
	int int_falls = 0;
	int pic_lines = 0;
	int run_len = 0;
	int line_samples = 0;
	int border_samples = 0;
	int frames_128 = 0;
	int frames_pent = 0;
	int int_checks_128 = 0;
	int int_checks_pent = 0;

	zx_ula u_dut (.*);

	always #2 clk14 = ~clk14;

	// video page model, attributes live at offset #1800..#1AFF
	function automatic logic [7:0] video_byte(input logic [13:0] offset);
		if (offset >= 14'h1800 && offset < 14'h1B00) begin
			return 8'h0E;
		end
		return 8'hAA;
	endfunction

	assign vd_in = va_lo_oe ? video_byte({va_hi[13], va_lo}) : cpu_data;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display("TB FAILED");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string test, input int expected, input int actual);
		abort_run($sformatf("MISMATCH %s expected %0d actual %0d", test, expected, actual));
	endtask

	task automatic drive_idle_bus();
		{a15, a14, a13, a1, a0} = 5'($random(seed));
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge clk14);
			drive_idle_bus();
		end
	endtask

	task automatic idle_until_vsync(input int target);
		@(posedge clk14);
		while (vs_rises < target) begin
			@(negedge clk14);
			drive_idle_bus();
			@(posedge clk14);
		end
	endtask

	// #FE decodes a0 low, #7FFD decodes a1 and a15 low
	task automatic io_write(input logic to_7ffd, input logic [7:0] data);
		@(negedge clk14);
		{a15, a1, a0} = to_7ffd ? 3'b001 : 3'b110;
		cpu_data = data;
		n_iorq = 1'b0;
		n_wr = 1'b0;
		repeat (2) @(negedge clk14);
		n_iorq = 1'b1;
		n_wr = 1'b1;
		idle_cycles(2);
	endtask

	task automatic read_port_fe();
		logic [7:0] expected;
		@(negedge clk14);
		kd = 5'($random(seed));
		tape_in = 1'($random(seed));
		{a15, a1, a0} = 3'b110;
		n_iorq = 1'b0;
		n_rd = 1'b0;
		expected = {1'b1, tape_in, 1'b1, kd};
		do @(negedge clk14); while (!vd_oe);
		assert (vd_out == expected) else report_mismatch("port FE read", expected, vd_out);
		n_iorq = 1'b1;
		n_rd = 1'b1;
		do @(negedge clk14); while (vd_oe);
	endtask

	// ROM read at #0000, then a RAM write at #4000 into page 5
	task automatic verify_strobes();
		@(negedge clk14);
		{a15, a14} = 2'b00;
		n_mreq = 1'b0;
		n_rd = 1'b0;
		@(negedge clk14);
		assert (!n_romcs) else report_mismatch("ROM select", 0, n_romcs);
		assert (n_vrd) else report_mismatch("RAM read strobe on ROM", 1, n_vrd);
		n_rd = 1'b1;
		{a15, a14} = 2'b01;
		n_wr = 1'b0;
		@(negedge clk14);
		assert (n_romcs) else report_mismatch("ROM select on RAM", 1, n_romcs);
		assert (!n_vwr) else report_mismatch("RAM write strobe", 0, n_vwr);
		assert (va_hi == {2'b11, 3'd5, a13})
			else report_mismatch("4000 page", {2'b11, 3'd5, a13}, va_hi);
		n_mreq = 1'b1;
		n_wr = 1'b1;
	endtask

	// memory read at #C000, the banked page shows on va_hi one cycle later
	task automatic check_bank(input logic [2:0] bank, input logic rom);
		@(negedge clk14);
		{a15, a14} = 2'b11;
		a13 = 1'($random(seed));
		n_mreq = 1'b0;
		n_rd = 1'b0;
		@(negedge clk14);
		assert (va_hi == {2'b11, bank, a13})
			else report_mismatch("C000 page", {2'b11, bank, a13}, va_hi);
		assert (rom_a14 == rom) else report_mismatch("rom select", rom, rom_a14);
		assert (!n_vrd) else report_mismatch("RAM read strobe", 0, n_vrd);
		n_mreq = 1'b1;
		n_rd = 1'b1;
	endtask

	always @(posedge clk14) begin
		cycle <= cycle + 1;
		sel_q <= timing_sel;
		if (cycle >= TIMEOUT_CYCLES) begin
			abort_run($sformatf("timeout after %0d cycles", cycle));
		end
	end

	a_blank_black: assert property (@(posedge clk14) disable iff (!rst_n)
		(hsync || vsync) |-> ({r, g, b, i} == 4'b0000))
		else report_mismatch("blanking colour", 0, $sampled({r, g, b, i}));

	// composite sync is low during either sync alone
	a_csync: assert property (@(posedge clk14) disable iff (!rst_n)
		!(hsync && vsync) |-> (csync == !(hsync || vsync)))
		else report_mismatch("composite sync", !$sampled(hsync || vsync), $sampled(csync));

	// CPU clock is two cycles high and two low
	a_cpu_clock: assert property (@(posedge clk14) disable iff (!rst_n)
		$rose(clkcpu) |=> clkcpu ##1 !clkcpu ##1 !clkcpu ##1 clkcpu)
		else abort_run("clkcpu does not run at a quarter of clk14");

	// raster, interrupt and pixel monitor
	always @(negedge clk14) begin
		pix = {r, g, b, i};
		in_pic = (pix == INK_RGBI) || (pix == PAPER_RGBI);
		if (sel_q != sel_seen) begin
			sel_seen = sel_q;
			hs_valid = 1'b0;
			vs_valid = 1'b0;
		end
		if (hsync && !hsync_q) begin
			if (hs_valid) begin
				assert (cycle - hs_last == LINE_CYCLES)
					else report_mismatch("hsync period", LINE_CYCLES, cycle - hs_last);
				hs_checks++;
			end
			hs_last = cycle;
			hs_valid = 1'b1;
		end
		if (vsync && !vsync_q) begin
			if (vs_valid) begin
				frame_len = sel_q ? FRAME_128 : FRAME_PENT;
				assert (cycle - vs_last == frame_len)
					else report_mismatch("vsync period", frame_len, cycle - vs_last);
				assert (int_falls == 1) else report_mismatch("n_int per frame", 1, int_falls);
				assert (pic_lines == 192) else report_mismatch("picture lines", 192, pic_lines);
				if (sel_q) begin
					frames_128++;
				end else begin
					frames_pent++;
				end
			end
			vs_last = cycle;
			vs_valid = 1'b1;
			vs_rises++;
			int_falls = 0;
			pic_lines = 0;
		end
		if (!n_int && n_int_q) begin
			int_falls++;
			int_start = cycle;
			int_open = 1'b1;
		end
		if (n_int && !n_int_q && int_open) begin
			int_width = sel_q ? 128 : 132;
			assert (cycle - int_start == int_width)
				else report_mismatch("n_int width", int_width, cycle - int_start);
			if (sel_q) begin
				int_checks_128++;
			end else begin
				int_checks_pent++;
			end
			int_open = 1'b0;
		end
		// picture runs start on ink and toggle every pixel of two cycles
		if (vs_rises > 0) begin
			if (!in_pic && pix != 4'b0000) begin
				assert (pix == BORDER_RGBI) else report_mismatch("border colour", BORDER_RGBI, pix);
				border_samples++;
			end
			if (in_pic) begin
				if (!pic_q) begin
					assert (pix == INK_RGBI) else report_mismatch("first pixel", INK_RGBI, pix);
					line_samples = 0;
					run_len = 0;
				end else if (pix != pix_q) begin
					assert (run_len == 2) else report_mismatch("pixel width", 2, run_len);
					run_len = 0;
				end
				run_len++;
				line_samples++;
			end else if (pic_q) begin
				assert (run_len == 2) else report_mismatch("pixel width", 2, run_len);
				assert (line_samples == 512)
					else report_mismatch("picture samples per line", 512, line_samples);
				pic_lines++;
			end
		end
		hsync_q = hsync;
		vsync_q = vsync;
		n_int_q = n_int;
		pix_q = pix;
		pic_q = in_pic;
	end

	initial begin
		seed = 32'ha78d_9e7e;
		rst_n = 1'b0;
		timing_sel = 1'b1;
		{a15, a14, a13, a1, a0} = 5'b11111;
		{n_rd, n_wr, n_mreq, n_iorq, n_m1, n_rfsh} = 6'b111111;
		cpu_data = 8'h00;
		kd = 5'b11111;
		tape_in = 1'b0;
		repeat (16) @(negedge clk14);
		rst_n = 1'b1;
		idle_cycles(8);
		// border 4 with tape out high, then border 4 with the beeper high
		io_write(1'b0, 8'h0C);
		assert (tape_out == 1'b1) else report_mismatch("tape out", 1, tape_out);
		assert (beeper == 1'b0) else report_mismatch("beeper", 0, beeper);
		io_write(1'b0, 8'h14);
		assert (beeper == 1'b1) else report_mismatch("beeper", 1, beeper);
		assert (tape_out == 1'b0) else report_mismatch("tape out", 0, tape_out);
		repeat (4) read_port_fe();
		verify_strobes();
		io_write(1'b1, 8'h13);
		check_bank(3'd3, 1'b1);
		// lock set here, the next write must be ignored
		io_write(1'b1, 8'h25);
		check_bank(3'd5, 1'b0);
		io_write(1'b1, 8'h1a);
		check_bank(3'd5, 1'b0);
		idle_until_vsync(2);
		@(negedge clk14);
		timing_sel = 1'b0;
		idle_until_vsync(4);
		if (hs_checks > 0 && frames_128 > 0 && frames_pent > 0 && int_checks_128 > 0 &&
			int_checks_pent > 0 && border_samples > 0) begin
			$display("TB PASSED");
			$finish;
		end else begin
			abort_run("raster checks were not reached in both frame formats");
		end
	end

endmodule

`default_nettype wire

//--- ula_config.svh
`ifndef ULA_CONFIG_SVH
`define ULA_CONFIG_SVH

// picture area and the lead of the fetch ahead of the pixel output
`define ULA_H_AREA          256
`define ULA_V_AREA          192
`define ULA_SCREEN_DELAY    8

// 128K frame, 448 pixels by 311 lines
`define ULA_H_RBORDER_128   (60 + `ULA_SCREEN_DELAY)
`define ULA_H_BLANK1_128    16
`define ULA_H_SYNC_128      33
`define ULA_H_BLANK2_128    19
`define ULA_H_LBORDER_128   (64 - `ULA_SCREEN_DELAY)
`define ULA_H_TOTAL_128     (`ULA_H_AREA + `ULA_H_RBORDER_128 + `ULA_H_BLANK1_128 + \
	`ULA_H_SYNC_128 + `ULA_H_BLANK2_128 + `ULA_H_LBORDER_128)
`define ULA_V_BBORDER_128   47
`define ULA_V_SYNC_128      8
`define ULA_V_TBORDER_128   64
`define ULA_V_TOTAL_128     (`ULA_V_AREA + `ULA_V_BBORDER_128 + `ULA_V_SYNC_128 + \
	`ULA_V_TBORDER_128)

// Pentagon frame, 448 pixels by 320 lines
`define ULA_H_RBORDER_PENT  (56 + `ULA_SCREEN_DELAY)
`define ULA_H_BLANK1_PENT   8
`define ULA_H_SYNC_PENT     33
`define ULA_H_BLANK2_PENT   23
`define ULA_H_LBORDER_PENT  (72 - `ULA_SCREEN_DELAY)
`define ULA_H_TOTAL_PENT    (`ULA_H_AREA + `ULA_H_RBORDER_PENT + `ULA_H_BLANK1_PENT + \
	`ULA_H_SYNC_PENT + `ULA_H_BLANK2_PENT + `ULA_H_LBORDER_PENT)
`define ULA_V_BBORDER_PENT  56
`define ULA_V_SYNC_PENT     8
`define ULA_V_TBORDER_PENT  64
`define ULA_V_TOTAL_PENT    (`ULA_V_AREA + `ULA_V_BBORDER_PENT + `ULA_V_SYNC_PENT + \
	`ULA_V_TBORDER_PENT)

// interrupt line and pixel window [from, to)
`define ULA_INT_V_128       248
`define ULA_INT_H_FROM_128  0
`define ULA_INT_H_TO_128    64
`define ULA_INT_V_PENT      239
`define ULA_INT_H_FROM_PENT 318
`define ULA_INT_H_TO_PENT   384

`endif

//--- ula_pkg.sv
`default_nettype none

package ula_pkg;

	// raster position, hc is hc0 without the half-pixel bit
	typedef struct packed {
		logic [9:0] hc0;
		logic [8:0] hc;
		logic [8:0] vc;
	} raster_t;

	typedef struct packed {
		logic hsync;
		logic vsync;
		logic csync;
		logic blank;
	} sync_t;

	typedef struct packed {
		logic r;
		logic g;
		logic b;
		logic i;
	} rgbi_t;

	// the part of the Z80 bus the ULA decodes, strobes active low
	typedef struct packed {
		logic a15;
		logic a14;
		logic a13;
		logic a1;
		logic a0;
		logic n_rd;
		logic n_wr;
		logic n_mreq;
		logic n_iorq;
		logic n_m1;
		logic n_rfsh;
	} cpu_bus_t;

	// port #7FFD contents
	typedef struct packed {
		logic [2:0] rambank;
		logic vbank;
		logic rombank;
		logic lock;
	} paging_t;

endpackage

`default_nettype wire

//--- video_timing.sv
`default_nettype none

`include "ula_config.svh"

module video_timing (
	input  wire               clk14,
	input  wire               rst_n,
	input  wire               timing_sel,
	output ula_pkg::raster_t  raster,
	output ula_pkg::sync_t    sync,
	output logic              ck7,
	output logic              frame_start,
	output logic              n_int,
	output logic              clkcpu
);
	logic [9:0] hc0;
	logic [8:0] hc;
	logic [8:0] vc;
	logic [8:0] h_total;
	logic [8:0] v_total;
	logic [8:0] h_blank_from;
	logic [8:0] h_sync_from;
	logic [8:0] h_sync_to;
	logic [8:0] h_blank_to;
	logic [8:0] v_sync_from;
	logic [8:0] v_sync_to;
	logic [8:0] int_v;
	logic [8:0] int_from;
	logic [8:0] int_to;
	logic line_end;
	logic frame_end;
	logic hsync0;
	logic vsync0;
	logic blank0;
	logic int0;

	assign hc = hc0[9:1];
	assign ck7 = hc0[0];
	assign raster = '{hc0: hc0, hc: hc, vc: vc};

	// window edges of the selected format, timing_sel high is 128K
	always_comb begin
		if (timing_sel) begin
			h_total = 9'(`ULA_H_TOTAL_128);
			v_total = 9'(`ULA_V_TOTAL_128);
			h_blank_from = 9'(`ULA_H_AREA + `ULA_H_RBORDER_128);
			h_sync_from = h_blank_from + 9'(`ULA_H_BLANK1_128);
			h_sync_to = h_sync_from + 9'(`ULA_H_SYNC_128);
			h_blank_to = h_sync_to + 9'(`ULA_H_BLANK2_128);
			v_sync_from = 9'(`ULA_V_AREA + `ULA_V_BBORDER_128);
			v_sync_to = v_sync_from + 9'(`ULA_V_SYNC_128);
			int_v = 9'(`ULA_INT_V_128);
			int_from = 9'(`ULA_INT_H_FROM_128);
			int_to = 9'(`ULA_INT_H_TO_128);
		end else begin
			h_total = 9'(`ULA_H_TOTAL_PENT);
			v_total = 9'(`ULA_V_TOTAL_PENT);
			h_blank_from = 9'(`ULA_H_AREA + `ULA_H_RBORDER_PENT);
			h_sync_from = h_blank_from + 9'(`ULA_H_BLANK1_PENT);
			h_sync_to = h_sync_from + 9'(`ULA_H_SYNC_PENT);
			h_blank_to = h_sync_to + 9'(`ULA_H_BLANK2_PENT);
			v_sync_from = 9'(`ULA_V_AREA + `ULA_V_BBORDER_PENT);
			v_sync_to = v_sync_from + 9'(`ULA_V_SYNC_PENT);
			int_v = 9'(`ULA_INT_V_PENT);
			int_from = 9'(`ULA_INT_H_FROM_PENT);
			int_to = 9'(`ULA_INT_H_TO_PENT);
		end
	end

	// >= so a format switch mid-frame still wraps cleanly
	assign line_end = hc0 >= {h_total - 9'd1, 1'b1};
	assign frame_end = vc >= v_total - 9'd1;

	assign hsync0 = (hc >= h_sync_from) && (hc < h_sync_to);
	assign vsync0 = (vc >= v_sync_from) && (vc < v_sync_to);
	assign blank0 = vsync0 || ((hc >= h_blank_from) && (hc < h_blank_to));
	assign int0 = (vc == int_v) && (hc >= int_from) && (hc < int_to);

	always_ff @(posedge clk14 or negedge rst_n) begin
		if (!rst_n) begin
			hc0 <= '0;
			vc <= '0;
			frame_start <= 1'b0;
			sync <= '{hsync: 1'b0, vsync: 1'b0, csync: 1'b1, blank: 1'b0};
			n_int <= 1'b1;
			clkcpu <= 1'b0;
		end else begin
			frame_start <= line_end && frame_end;
			if (line_end) begin
				hc0 <= '0;
				vc <= frame_end ? 9'd0 : vc + 9'd1;
			end else begin
				hc0 <= hc0 + 10'd1;
			end
			// composite sync is active low
			if (ck7) begin
				sync <= '{hsync: hsync0, vsync: vsync0, csync: ~(hsync0 ^ vsync0), blank: blank0};
			end
			n_int <= ~int0;
			clkcpu <= hc[0];
		end
	end

	a_hc_in_line: assert property (@(posedge clk14) disable iff (!rst_n) hc < h_total)
		else $error("hc reached the line total");

endmodule

`default_nettype wire

//--- zx_ula.sv
`default_nettype none

module zx_ula (
	input  wire           clk14,
	input  wire           rst_n,
	input  wire           timing_sel,
	input  wire           a15,
	input  wire           a14,
	input  wire           a13,
	input  wire           a1,
	input  wire           a0,
	input  wire           n_rd,
	input  wire           n_wr,
	input  wire           n_mreq,
	input  wire           n_iorq,
	input  wire           n_m1,
	input  wire           n_rfsh,
	input  wire [7:0]     vd_in,
	output logic [7:0]    vd_out,
	output logic          vd_oe,
	output logic [18:13]  va_hi,
	output logic [12:0]   va_lo,
	output logic          va_lo_oe,
	output logic          n_romcs,
	output logic          n_vrd,
	output logic          n_vwr,
	output logic          rom_a14,
	output logic          n_int,
	output logic          clkcpu,
	input  wire [4:0]     kd,
	input  wire           tape_in,
	output logic          tape_out,
	output logic          beeper,
	output logic          r,
	output logic          g,
	output logic          b,
	output logic          i,
	output logic          hsync,
	output logic          vsync,
	output logic          csync
);
	ula_pkg::cpu_bus_t cpu;
	ula_pkg::raster_t raster;
	ula_pkg::sync_t sync;
	ula_pkg::rgbi_t rgbi;
	ula_pkg::paging_t paging;
	logic ck7;
	logic frame_start;
	logic [2:0] border;
	logic screen_read;
	logic [13:0] screen_addr;

	assign cpu = {a15, a14, a13, a1, a0, n_rd, n_wr, n_mreq, n_iorq, n_m1, n_rfsh};

	assign {r, g, b, i} = rgbi;
	assign hsync = sync.hsync;
	assign vsync = sync.vsync;
	assign csync = sync.csync;

	video_timing u_timing (
		.clk14(clk14), .rst_n(rst_n), .timing_sel(timing_sel),
		.raster(raster), .sync(sync), .ck7(ck7), .frame_start(frame_start),
		.n_int(n_int), .clkcpu(clkcpu)
	);

	screen_fetch u_fetch (
		.clk14(clk14), .rst_n(rst_n), .raster(raster), .sync(sync), .ck7(ck7),
		.frame_start(frame_start), .cpu(cpu), .border(border), .vd_in(vd_in),
		.rgbi(rgbi), .screen_read(screen_read), .screen_addr(screen_addr)
	);

	io_ports u_ports (
		.clk14(clk14), .rst_n(rst_n), .cpu(cpu), .vd_in(vd_in), .kd(kd),
		.tape_in(tape_in), .border(border), .beeper(beeper), .tape_out(tape_out),
		.paging(paging), .vd_out(vd_out), .vd_oe(vd_oe)
	);

	mem_decoder u_mem (
		.clk14(clk14), .rst_n(rst_n), .cpu(cpu), .paging(paging),
		.screen_read(screen_read), .screen_addr(screen_addr), .n_romcs(n_romcs),
		.n_vrd(n_vrd), .n_vwr(n_vwr), .rom_a14(rom_a14), .va_hi(va_hi),
		.va_lo(va_lo), .va_lo_oe(va_lo_oe)
	);

endmodule

`default_nettype wire
